// ==== common/adc_pkg.sv ====
`default_nettype none

package adc_pkg;

    // Raw converter word width.
    localparam int ADC_RAW_W = 14;

    // Converted sample width.
    localparam int SAMPLE_W = 16;

    // Offset-binary word as it arrives on the ADC pins.
    typedef logic [ADC_RAW_W-1:0] adc_raw_t;

    // Two's complement sample after conversion.
    typedef logic signed [SAMPLE_W-1:0] sample_t;

endpackage

`default_nettype wire

// ==== common/link_pkg.sv ====
`default_nettype none

package link_pkg;

    // UART payload width.
    localparam int BYTE_W = 8;

    typedef logic [BYTE_W-1:0] byte_t;

    // Opens every output frame.
    localparam byte_t FRAME_SYNC = 8'hA5;

    // Frame packer FSM.
    typedef enum logic [2:0] {
        PK_IDLE,
        PK_SEND_SYNC,
        PK_SEND_HIGH,
        PK_SEND_LOW,
        PK_WAIT_ACK
    } packer_state_t;

    // 8N1 serializer FSM.
    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;

endpackage

`default_nettype wire

// ==== adc_front/adc_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module adc_capture #(
    parameter int ADC_SETTLE = 16
) (
    input  wire                 sys_clock,
    input  wire                 i_rst_n,
    input  wire adc_pkg::adc_raw_t i_adc_data,
    input  wire                 i_adc_valid,
    output adc_pkg::sample_t    o_sample,
    output logic                o_valid,
    output logic                o_ready
);

    localparam int CNT_W = (ADC_SETTLE > 0) ? $clog2(ADC_SETTLE + 1) : 1;
    localparam int EXT_W = adc_pkg::SAMPLE_W - adc_pkg::ADC_RAW_W;

    logic [CNT_W-1:0]    settle_cnt;
    logic                settled;
    adc_pkg::sample_t    converted;

    assign settled = (settle_cnt == CNT_W'(ADC_SETTLE));

    // Offset binary becomes two's complement by flipping the MSB and sign extending.
    assign converted = {
        {EXT_W{~i_adc_data[adc_pkg::ADC_RAW_W-1]}},
        ~i_adc_data[adc_pkg::ADC_RAW_W-1],
        i_adc_data[adc_pkg::ADC_RAW_W-2:0]
    };

    // Count accepted words until the converter has settled.
    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            settle_cnt <= '0;
            o_valid    <= 1'b0;
            o_ready    <= 1'b0;
        end else begin
            if (i_adc_valid && !settled) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
            o_valid <= i_adc_valid && settled;
            o_ready <= settled;
        end
    end

    always_ff @(posedge sys_clock) begin
        if (i_adc_valid) begin
            o_sample <= converted;
        end
    end

    // No sample may leave before the settle window closes.
    a_valid_after_ready: assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        o_valid |-> o_ready
    );

endmodule

`default_nettype wire

// ==== adc_front/sample_decimator.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_decimator #(
    parameter int DECIM_LOG2 = 2
) (
    input  wire                 sys_clock,
    input  wire                 i_rst_n,
    input  wire adc_pkg::sample_t i_sample,
    input  wire                 i_valid,
    output adc_pkg::sample_t    o_mean,
    output logic                o_valid
);

    localparam int ACC_W = adc_pkg::SAMPLE_W + DECIM_LOG2;
    localparam int CNT_W = (DECIM_LOG2 > 0) ? DECIM_LOG2 : 1;
    localparam int GROUP = 1 << DECIM_LOG2;

    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] acc_sum;
    logic [CNT_W-1:0]        grp_cnt;
    logic                    grp_last;

    assign acc_sum  = acc + i_sample;
    assign grp_last = (grp_cnt == CNT_W'(GROUP - 1));

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            acc     <= '0;
            grp_cnt <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            if (i_valid) begin
                if (grp_last) begin
                    // Last sample of the group emits the mean and restarts.
                    acc     <= '0;
                    grp_cnt <= '0;
                    o_valid <= 1'b1;
                end else begin
                    acc     <= acc_sum;
                    grp_cnt <= grp_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge sys_clock) begin
        if (i_valid && grp_last) begin
            o_mean <= adc_pkg::sample_t'(acc_sum >>> DECIM_LOG2);
        end
    end

    a_valid_follows_input: assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        o_valid |-> $past(i_valid)
    );

endmodule

`default_nettype wire

// ==== logic/frame_packer.sv ====
`timescale 1ns/1ns
`default_nettype none

module frame_packer (
    input  wire                 sys_clock,
    input  wire                 i_rst_n,
    input  wire adc_pkg::sample_t i_mean,
    input  wire                 i_valid,
    input  wire                 i_wb_ack,
    output logic                o_wb_cyc,
    output logic                o_wb_stb,
    output logic                o_wb_we,
    output link_pkg::byte_t     o_wb_dat,
    output logic                o_overrun
);

    link_pkg::packer_state_t state;
    link_pkg::packer_state_t ret_state;
    adc_pkg::sample_t        mean_q;

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            state     <= link_pkg::PK_IDLE;
            ret_state <= link_pkg::PK_IDLE;
            o_wb_cyc  <= 1'b0;
            o_wb_stb  <= 1'b0;
            o_wb_we   <= 1'b0;
            o_overrun <= 1'b0;
        end else begin
            // Sticky because the converter cannot be held off.
            if (i_valid && state != link_pkg::PK_IDLE) begin
                o_overrun <= 1'b1;
            end
            case (state)
                link_pkg::PK_IDLE: begin
                    if (i_valid) begin
                        state <= link_pkg::PK_SEND_SYNC;
                    end
                end
                link_pkg::PK_SEND_SYNC: begin
                    o_wb_cyc  <= 1'b1;
                    o_wb_stb  <= 1'b1;
                    o_wb_we   <= 1'b1;
                    ret_state <= link_pkg::PK_SEND_HIGH;
                    state     <= link_pkg::PK_WAIT_ACK;
                end
                link_pkg::PK_SEND_HIGH: begin
                    o_wb_stb  <= 1'b1;
                    ret_state <= link_pkg::PK_SEND_LOW;
                    state     <= link_pkg::PK_WAIT_ACK;
                end
                link_pkg::PK_SEND_LOW: begin
                    o_wb_stb  <= 1'b1;
                    ret_state <= link_pkg::PK_IDLE;
                    state     <= link_pkg::PK_WAIT_ACK;
                end
                link_pkg::PK_WAIT_ACK: begin
                    if (i_wb_ack) begin
                        // Strobe stays low for at least one cycle.
                        o_wb_stb <= 1'b0;
                        state    <= ret_state;
                        if (ret_state == link_pkg::PK_IDLE) begin
                            o_wb_cyc <= 1'b0;
                            o_wb_we  <= 1'b0;
                        end
                    end
                end
                default: begin
                    state <= link_pkg::PK_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge sys_clock) begin
        if (state == link_pkg::PK_IDLE && i_valid) begin
            mean_q <= i_mean;
        end
        case (state)
            link_pkg::PK_SEND_SYNC: o_wb_dat <= link_pkg::FRAME_SYNC;
            link_pkg::PK_SEND_HIGH: o_wb_dat <= mean_q[adc_pkg::SAMPLE_W-1 -: link_pkg::BYTE_W];
            link_pkg::PK_SEND_LOW:  o_wb_dat <= mean_q[link_pkg::BYTE_W-1:0];
            default: ;
        endcase
    end

    // Bus rule towards the UART.
    a_stb_held: assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        o_wb_stb && !i_wb_ack |=> o_wb_stb && $stable(o_wb_dat)
    );

endmodule

`default_nettype wire

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ns
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 5208
) (
    input  wire                 sys_clock,
    input  wire                 i_rst_n,
    input  wire                 i_wb_cyc,
    input  wire                 i_wb_stb,
    input  wire                 i_wb_we,
    input  wire link_pkg::byte_t i_wb_dat,
    output logic                o_wb_ack,
    output logic                o_tx
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int IDX_W = $clog2(link_pkg::BYTE_W);

    link_pkg::uart_state_t state;
    logic [CNT_W-1:0]      clk_cnt;
    logic [IDX_W-1:0]      bit_idx;
    logic                  bit_end;
    link_pkg::byte_t       shift_q;

    assign bit_end = (clk_cnt == CNT_W'(CLKS_PER_BIT - 1));

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            state    <= link_pkg::UART_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            o_wb_ack <= 1'b0;
            o_tx     <= 1'b1;
        end else begin
            clk_cnt <= bit_end ? '0 : clk_cnt + 1'b1;
            case (state)
                link_pkg::UART_IDLE: begin
                    clk_cnt <= '0;
                    if (o_wb_ack) begin
                        // Start bit begins with the acked cycle.
                        o_wb_ack <= 1'b0;
                        o_tx     <= 1'b0;
                        state    <= link_pkg::UART_START;
                    end else if (i_wb_cyc && i_wb_stb && i_wb_we) begin
                        o_wb_ack <= 1'b1;
                    end
                end
                link_pkg::UART_START: begin
                    if (bit_end) begin
                        o_tx    <= shift_q[0];
                        bit_idx <= '0;
                        state   <= link_pkg::UART_DATA;
                    end
                end
                link_pkg::UART_DATA: begin
                    if (bit_end) begin
                        if (bit_idx == IDX_W'(link_pkg::BYTE_W - 1)) begin
                            o_tx  <= 1'b1;
                            state <= link_pkg::UART_STOP;
                        end else begin
                            o_tx    <= shift_q[1];
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                link_pkg::UART_STOP: begin
                    if (bit_end) begin
                        state <= link_pkg::UART_IDLE;
                    end
                end
                default: begin
                    state <= link_pkg::UART_IDLE;
                end
            endcase
        end
    end

    // LSB first.
    always_ff @(posedge sys_clock) begin
        if (state == link_pkg::UART_IDLE && o_wb_ack) begin
            shift_q <= i_wb_dat;
        end else if (state == link_pkg::UART_DATA && bit_end) begin
            shift_q <= shift_q >> 1;
        end
    end

    a_ack_in_cycle: assert property (
        @(posedge sys_clock) disable iff (!i_rst_n)
        o_wb_ack |-> i_wb_cyc && i_wb_stb
    );

endmodule

`default_nettype wire

// ==== logic/status_led.sv ====
`timescale 1ns/1ns
`default_nettype none

module status_led #(
    parameter int LED_PERIOD = 50_000_000
) (
    input  wire     sys_clock,
    input  wire     i_rst_n,
    input  wire     i_ready,
    output logic    o_led_g,
    output logic    o_led_r
);

    localparam int CNT_W = $clog2(LED_PERIOD + 1);

    logic [CNT_W-1:0] period_cnt;
    logic             pulse;

    always_ff @(posedge sys_clock) begin
        if (!i_rst_n) begin
            period_cnt <= '0;
            pulse      <= 1'b0;
        end else if (period_cnt == CNT_W'(LED_PERIOD)) begin
            period_cnt <= '0;
            pulse      <= 1'b1;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            pulse      <= 1'b0;
        end
    end

    // Green while settling, red once ready.
    assign o_led_g = pulse && !i_ready;
    assign o_led_r = pulse && i_ready;

endmodule

`default_nettype wire

// ==== logic/scope_link_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module scope_link_top #(
    parameter int ADC_SETTLE   = 16,
    parameter int DECIM_LOG2   = 2,
    parameter int CLKS_PER_BIT = 5208,
    parameter int LED_PERIOD   = 50_000_000
) (
    input  wire                 sys_clock,
    input  wire                 i_rst_n,
    input  wire adc_pkg::adc_raw_t i_adc_data,
    input  wire                 i_adc_valid,
    output logic                o_tx,
    output logic                o_led_g,
    output logic                o_led_r,
    output logic                o_overrun
);

    adc_pkg::sample_t   cap_sample;
    logic               cap_valid;
    logic               cap_ready;

    adc_pkg::sample_t   dec_mean;
    logic               dec_valid;

    logic               wb_cyc;
    logic               wb_stb;
    logic               wb_we;
    link_pkg::byte_t    wb_dat;
    logic               wb_ack;

    adc_capture #(
        .ADC_SETTLE     ( ADC_SETTLE    )
    ) u_adc_capture (
        .sys_clock      ( sys_clock     ),
        .i_rst_n        ( i_rst_n       ),
        .i_adc_data     ( i_adc_data    ),
        .i_adc_valid    ( i_adc_valid   ),
        .o_sample       ( cap_sample    ),
        .o_valid        ( cap_valid     ),
        .o_ready        ( cap_ready     )
    );

    sample_decimator #(
        .DECIM_LOG2     ( DECIM_LOG2    )
    ) u_sample_decimator (
        .sys_clock      ( sys_clock     ),
        .i_rst_n        ( i_rst_n       ),
        .i_sample       ( cap_sample    ),
        .i_valid        ( cap_valid     ),
        .o_mean         ( dec_mean      ),
        .o_valid        ( dec_valid     )
    );

    frame_packer u_frame_packer (
        .sys_clock      ( sys_clock     ),
        .i_rst_n        ( i_rst_n       ),
        .i_mean         ( dec_mean      ),
        .i_valid        ( dec_valid     ),
        .i_wb_ack       ( wb_ack        ),
        .o_wb_cyc       ( wb_cyc        ),
        .o_wb_stb       ( wb_stb        ),
        .o_wb_we        ( wb_we         ),
        .o_wb_dat       ( wb_dat        ),
        .o_overrun      ( o_overrun     )
    );

    uart_tx #(
        .CLKS_PER_BIT   ( CLKS_PER_BIT  )
    ) u_uart_tx (
        .sys_clock      ( sys_clock     ),
        .i_rst_n        ( i_rst_n       ),
        .i_wb_cyc       ( wb_cyc        ),
        .i_wb_stb       ( wb_stb        ),
        .i_wb_we        ( wb_we         ),
        .i_wb_dat       ( wb_dat        ),
        .o_wb_ack       ( wb_ack        ),
        .o_tx           ( o_tx          )
    );

    status_led #(
        .LED_PERIOD     ( LED_PERIOD    )
    ) u_status_led (
        .sys_clock      ( sys_clock     ),
        .i_rst_n        ( i_rst_n       ),
        .i_ready        ( cap_ready     ),
        .o_led_g        ( o_led_g       ),
        .o_led_r        ( o_led_r       )
    );

endmodule

`default_nettype wire

// ==== verif/tb_scope_link.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_scope_link;

    localparam int ADC_SETTLE     = 4;
    localparam int DECIM_LOG2     = 2;
    localparam int CLKS_PER_BIT   = 8;
    localparam int LED_PERIOD     = 20;
    localparam int GROUP          = 1 << DECIM_LOG2;
    localparam int RESET_CYCLES   = 16;
    localparam int GROUP_GAP      = 400;
    localparam int NUM_RANDOM     = 5;
    localparam int READY_LAG      = 2;
    localparam int TIMEOUT_CYCLES = 12 * GROUP_GAP + 2000;

    // Alternating nibbles mark a frame start.
    localparam logic [7:0] SYNC_BYTE = {4'b1010, 4'b0101};

    logic               sys_clock;
    logic               i_rst_n;
    adc_pkg::adc_raw_t  i_adc_data;
    logic               i_adc_valid;
    logic               o_tx;
    logic               o_led_g;
    logic               o_led_r;
    logic               o_overrun;

    int                 seed = 51821;
    adc_pkg::adc_raw_t  grp_raw [GROUP];
    logic [7:0]         rx_q [$];
    logic [15:0]        exp_q [$];
    int                 samples_sent = 0;
    int                 frames_expected = 0;
    int                 frames_checked = 0;
    int                 cycle_count = 0;
    int                 settle_age = 0;
    int                 green_early = 0;
    int                 red_seen = 0;
    bit                 rst_done = 1'b0;
    bit                 burst_sent = 1'b0;
    bit                 overrun_seen = 1'b0;

    scope_link_top #(
        .ADC_SETTLE     ( ADC_SETTLE    ),
        .DECIM_LOG2     ( DECIM_LOG2    ),
        .CLKS_PER_BIT   ( CLKS_PER_BIT  ),
        .LED_PERIOD     ( LED_PERIOD    )
    ) dut (
        .sys_clock      ( sys_clock     ),
        .i_rst_n        ( i_rst_n       ),
        .i_adc_data     ( i_adc_data    ),
        .i_adc_valid    ( i_adc_valid   ),
        .o_tx           ( o_tx          ),
        .o_led_g        ( o_led_g       ),
        .o_led_r        ( o_led_r       ),
        .o_overrun      ( o_overrun     )
    );

    initial begin : clock_gen
        sys_clock = 1'b0;
        forever begin
            #10 sys_clock = ~sys_clock;
        end
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("sim failed");
        $fatal(1, "first error ends the run");
    endtask

    task automatic report_mismatch(input string test, input logic [31:0] expected,
                                   input logic [31:0] actual);
        report_failure($sformatf("mismatch %s: expected %0h actual %0h", test, expected, actual));
    endtask

    // Offset binary has its zero at mid scale.
    function automatic int offset_value(input adc_pkg::adc_raw_t raw);
        return int'(raw) - (1 << (adc_pkg::ADC_RAW_W - 1));
    endfunction

    // Rounds toward minus infinity.
    function automatic int floor_div(input int num, input int den);
        int q;
        q = num / den;
        if ((num % den) != 0 && num < 0) begin
            q = q - 1;
        end
        return q;
    endfunction

    function automatic adc_pkg::adc_raw_t random_code();
        int r;
        r = $random(seed);
        return r[adc_pkg::ADC_RAW_W-1:0];
    endfunction

    task automatic fill_random();
        for (int i = 0; i < GROUP; i++) begin
            grp_raw[i] = random_code();
        end
    endtask

    task automatic load_group(input adc_pkg::adc_raw_t a, input adc_pkg::adc_raw_t b,
                              input adc_pkg::adc_raw_t c, input adc_pkg::adc_raw_t d);
        grp_raw[0] = a;
        grp_raw[1] = b;
        grp_raw[2] = c;
        grp_raw[3] = d;
    endtask

    task automatic drive_sample(input adc_pkg::adc_raw_t raw);
        @(posedge sys_clock);
        i_adc_data   <= raw;
        i_adc_valid  <= 1'b1;
        samples_sent = samples_sent + 1;
    endtask

    task automatic end_strobes();
        @(posedge sys_clock);
        i_adc_valid <= 1'b0;
    endtask

    // Sends grp_raw back to back; keep says whether a frame must follow.
    task automatic send_group(input bit keep);
        int sum;
        sum = 0;
        for (int i = 0; i < GROUP; i++) begin
            sum = sum + offset_value(grp_raw[i]);
            drive_sample(grp_raw[i]);
        end
        if (keep) begin
            exp_q.push_back(16'(floor_div(sum, GROUP)));
            frames_expected = frames_expected + 1;
        end
    endtask

    // UART receiver that samples the line at mid-bit.
    initial begin : uart_model
        logic [7:0] shift;
        while (!rst_done) begin
            @(negedge sys_clock);
        end
        forever begin
            @(negedge sys_clock);
            if (o_tx === 1'b0) begin
                repeat (CLKS_PER_BIT / 2) @(negedge sys_clock);
                assert (o_tx === 1'b0)
                    else report_mismatch("start bit", 0, o_tx);
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS_PER_BIT) @(negedge sys_clock);
                    shift[i] = o_tx;
                end
                repeat (CLKS_PER_BIT) @(negedge sys_clock);
                assert (o_tx === 1'b1)
                    else report_mismatch("stop bit", 1, o_tx);
                rx_q.push_back(shift);
            end
        end
    end

    initial begin : frame_checker
        logic [7:0]  sync_b;
        logic [7:0]  high_b;
        logic [7:0]  low_b;
        logic [15:0] mean_exp;
        forever begin
            @(posedge sys_clock);
            if (rx_q.size() >= 3) begin
                sync_b = rx_q.pop_front();
                high_b = rx_q.pop_front();
                low_b  = rx_q.pop_front();
                assert (exp_q.size() > 0)
                    else report_failure("a frame arrived with no sample group behind it");
                mean_exp = exp_q.pop_front();
                assert (sync_b == SYNC_BYTE)
                    else report_mismatch($sformatf("frame %0d sync", frames_checked),
                                         SYNC_BYTE, sync_b);
                assert (high_b == mean_exp[15:8])
                    else report_mismatch($sformatf("frame %0d high byte", frames_checked),
                                         mean_exp[15:8], high_b);
                assert (low_b == mean_exp[7:0])
                    else report_mismatch($sformatf("frame %0d low byte", frames_checked),
                                         mean_exp[7:0], low_b);
                frames_checked = frames_checked + 1;
            end
        end
    end

    // LED, overrun and idle line watch.
    always @(negedge sys_clock) begin
        if (rst_done) begin
            if (samples_sent >= ADC_SETTLE) begin
                settle_age = settle_age + 1;
            end
            assert (!(o_led_g && o_led_r))
                else report_failure("green and red LED were high in the same cycle");
            if (o_led_g) begin
                assert (settle_age <= READY_LAG)
                    else report_failure("green LED pulsed after the link was ready");
                if (samples_sent < ADC_SETTLE) begin
                    green_early = green_early + 1;
                end
            end
            if (o_led_r) begin
                assert (settle_age > READY_LAG)
                    else report_failure("red LED pulsed before the link was ready");
                red_seen = red_seen + 1;
            end
            if (!burst_sent) begin
                assert (o_overrun === 1'b0)
                    else report_mismatch("overrun in spaced groups", 0, o_overrun);
            end
            if (o_overrun === 1'b1) begin
                overrun_seen = 1'b1;
            end
            assert (!overrun_seen || o_overrun === 1'b1)
                else report_mismatch("overrun held", 1, o_overrun);
            if (frames_expected == 0) begin
                assert (o_tx === 1'b1)
                    else report_mismatch("line idle before first group", 1, o_tx);
            end
        end
    end

    always @(posedge sys_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("timeout after %0d cycles, frames still outstanding",
                                     cycle_count));
        end
    end

    initial begin : stimulus
        i_rst_n     = 1'b0;
        i_adc_data  = '0;
        i_adc_valid = 1'b0;
        repeat (RESET_CYCLES) @(posedge sys_clock);
        i_rst_n  <= 1'b1;
        rst_done = 1'b1;
        @(negedge sys_clock);
        assert (o_tx === 1'b1)
            else report_mismatch("idle line after reset", 1, o_tx);

        // Let the green LED blink first.
        repeat (60) @(posedge sys_clock);

        for (int i = 0; i < ADC_SETTLE; i++) begin
            drive_sample(random_code());
        end
        end_strobes();
        repeat (GROUP_GAP) @(posedge sys_clock);
        assert (rx_q.size() == 0 && frames_checked == 0)
            else report_mismatch("settle discard", 0, rx_q.size());

        // Corner codes at both ends and around mid scale.
        load_group(14'h0000, 14'h2000, 14'h1FFF, 14'h3FFF);
        send_group(1'b1);
        end_strobes();
        repeat (GROUP_GAP) @(posedge sys_clock);
        load_group(14'h0000, 14'h0000, 14'h0000, 14'h0000);
        send_group(1'b1);
        end_strobes();
        repeat (GROUP_GAP) @(posedge sys_clock);
        load_group(14'h3FFF, 14'h3FFF, 14'h3FFF, 14'h3FFF);
        send_group(1'b1);
        end_strobes();
        repeat (GROUP_GAP) @(posedge sys_clock);

        for (int g = 0; g < NUM_RANDOM; g++) begin
            fill_random();
            send_group(1'b1);
            end_strobes();
            repeat (GROUP_GAP) @(posedge sys_clock);
        end

        // Second group lands while the first frame is on the line.
        burst_sent = 1'b1;
        fill_random();
        send_group(1'b1);
        fill_random();
        send_group(1'b0);
        end_strobes();

        while (frames_checked < frames_expected) begin
            @(posedge sys_clock);
        end
        repeat (GROUP_GAP) @(posedge sys_clock);
        assert (rx_q.size() == 0)
            else report_mismatch("dropped group sends nothing", 0, rx_q.size());
        assert (o_overrun === 1'b1)
            else report_mismatch("overrun after burst", 1, o_overrun);
        assert (green_early > 0)
            else report_failure("green LED never pulsed before the link was ready");
        assert (red_seen > 0)
            else report_failure("red LED never pulsed once the link was ready");
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
common/adc_pkg.sv
common/link_pkg.sv
adc_front/adc_capture.sv
adc_front/sample_decimator.sv
logic/frame_packer.sv
logic/uart_tx.sv
logic/status_led.sv
logic/scope_link_top.sv
verif/tb_scope_link.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the scope link testbench with Verilator.
# The exit status is nonzero when the testbench stops on an error.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_scope_link \
    -f build.f \
    -Mdir obj_dir

./obj_dir/Vtb_scope_link
